// ==== rtl/cp0_pkg.sv ====
package cp0_pkg;

    // Operations carried by the command port
    typedef enum logic [2:0] {
        OP_MFC0  = 3'd0,
        OP_MTC0  = 3'd1,
        OP_ERET  = 3'd2,
        OP_EXC   = 3'd3,
        OP_TLBP  = 3'd4,
        OP_TLBR  = 3'd5,
        OP_TLBWI = 3'd6
    } cp0_op_e;

    // Register addresses as {rd, sel} with sel always 0
    localparam logic [7:0] REG_INDEX    = {5'd0, 3'd0};
    localparam logic [7:0] REG_ENTRYLO0 = {5'd2, 3'd0};
    localparam logic [7:0] REG_ENTRYLO1 = {5'd3, 3'd0};
    localparam logic [7:0] REG_BADVADDR = {5'd8, 3'd0};
    localparam logic [7:0] REG_COUNT    = {5'd9, 3'd0};
    localparam logic [7:0] REG_ENTRYHI  = {5'd10, 3'd0};
    localparam logic [7:0] REG_COMPARE  = {5'd11, 3'd0};
    localparam logic [7:0] REG_STATUS   = {5'd12, 3'd0};
    localparam logic [7:0] REG_CAUSE    = {5'd13, 3'd0};
    localparam logic [7:0] REG_EPC      = {5'd14, 3'd0};

    // Cause.ExcCode values
    localparam logic [4:0] EXC_INT  = 5'h00;
    localparam logic [4:0] EXC_MOD  = 5'h01;  // TLB modified
    localparam logic [4:0] EXC_TLBL = 5'h02;  // TLB miss on load or fetch
    localparam logic [4:0] EXC_TLBS = 5'h03;  // TLB miss on store
    localparam logic [4:0] EXC_ADEL = 5'h04;
    localparam logic [4:0] EXC_ADES = 5'h05;
    localparam logic [4:0] EXC_SYS  = 5'h08;

    localparam int TLB_ENTRIES = 16;
    localparam int TLB_IDX_W   = 4;

    // BEV is fixed to one, so exceptions go to the boot vector
    localparam logic [31:0] EXC_VECTOR    = 32'hBFC0_0380;
    localparam logic [31:0] COMPARE_RESET = 32'h0001_55CC;

    // Bits that MTC0 may change
    localparam logic [31:0] STATUS_WMASK  = 32'h0000_FF03;  // IM, EXL, IE
    localparam logic [31:0] CAUSE_WMASK   = 32'h0000_0300;  // IP1, IP0
    localparam logic [31:0] ENTRYHI_WMASK = 32'hFFFF_E0FF;  // VPN2, ASID
    localparam logic [31:0] ENTRYLO_WMASK = 32'h03FF_FFFF;  // PFN, C, D, V, G
    localparam logic [31:0] INDEX_WMASK   = 32'h0000_000F;

endpackage

// ==== rtl/cp0_cmd_port.sv ====
`timescale 1ns/1ns

module cp0_cmd_port (
    input  logic             clk,
    input  logic             reset,
    input  logic             cmd_req,
    output logic             cmd_ack,
    input  cp0_pkg::cp0_op_e cmd_op,
    input  logic [7:0]       cmd_addr,
    input  logic [31:0]      cmd_wdata,
    input  logic [31:0]      cmd_pc,
    input  logic             cmd_bd,
    input  logic [4:0]       cmd_exc_code,
    input  logic [31:0]      cmd_badvaddr,
    input  logic             op_done,
    output logic             op_valid,
    output cp0_pkg::cp0_op_e op,
    output logic [7:0]       addr,
    output logic [31:0]      wdata,
    output logic [31:0]      pc,
    output logic             bd,
    output logic [4:0]       exc_code,
    output logic [31:0]      badvaddr
);
    typedef enum logic [1:0] {ST_IDLE, ST_BUSY, ST_ACK} state_e;

    state_e state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ST_IDLE;
            op_valid <= 1'b0;
            cmd_ack  <= 1'b0;
        end else begin
            op_valid <= 1'b0;  // Strobe lasts a single cycle
            case (state)
                ST_IDLE: begin
                    if (cmd_req) begin
                        op_valid <= 1'b1;
                        state    <= ST_BUSY;
                    end
                end
                ST_BUSY: begin
                    if (op_done) begin
                        cmd_ack <= 1'b1;
                        state   <= ST_ACK;
                    end
                end
                ST_ACK: begin
                    if (!cmd_req) begin  // Host released so the handshake closes
                        cmd_ack <= 1'b0;
                        state   <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Command fields are held until the next accepted request
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && cmd_req) begin
            op       <= cmd_op;
            addr     <= cmd_addr;
            wdata    <= cmd_wdata;
            pc       <= cmd_pc;
            bd       <= cmd_bd;
            exc_code <= cmd_exc_code;
            badvaddr <= cmd_badvaddr;
        end
    end

    // A completion only ever answers an operation in flight
    a_done_when_busy: assert property (@(posedge clk) disable iff (reset)
        op_done |-> state == ST_BUSY);

endmodule

// ==== rtl/cp0_regs.sv ====
`timescale 1ns/1ns

module cp0_regs (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            op_valid,
    input  cp0_pkg::cp0_op_e                op,
    input  logic [7:0]                      addr,
    input  logic [31:0]                     wdata,
    input  logic [31:0]                     pc,
    input  logic                            bd,
    input  logic [4:0]                      exc_code,
    input  logic [31:0]                     badvaddr,
    input  logic [5:0]                      ext_int,
    output logic [31:0]                     read_data,
    output logic [31:0]                     epc,
    output logic                            int_req,
    output logic [31:0]                     tlb_entryhi,
    output logic [31:0]                     tlb_entrylo0,
    output logic [31:0]                     tlb_entrylo1,
    output logic [cp0_pkg::TLB_IDX_W-1:0]   tlb_index,
    output logic                            tlb_we,
    input  logic                            probe_hit,
    input  logic [cp0_pkg::TLB_IDX_W-1:0]   probe_index,
    input  logic [31:0]                     rd_entryhi,
    input  logic [31:0]                     rd_entrylo0,
    input  logic [31:0]                     rd_entrylo1
);
    logic [7:0]  status_im;
    logic        status_exl;
    logic        status_ie;
    logic        cause_bd;
    logic        cause_ti;
    logic [1:0]  cause_ip_sw;
    logic [4:0]  cause_exc_code;
    logic [7:0]  cause_ip;
    logic [5:0]  ext_int_q;
    logic        tick;
    logic [31:0] count;
    logic [31:0] compare;
    logic [31:0] badvaddr_q;
    logic [31:0] entryhi;
    logic [31:0] entrylo0;
    logic [31:0] entrylo1;
    logic        index_p;
    logic [cp0_pkg::TLB_IDX_W-1:0] index_val;
    logic [31:0] wd_status;
    logic [31:0] wd_cause;
    logic [31:0] wd_index;
    logic        mtc0, is_exc, is_eret, is_tlbp, is_tlbr, is_tlbwi;
    logic        tlb_code, addr_code;

    assign mtc0     = op_valid && op == cp0_pkg::OP_MTC0;
    assign is_exc   = op_valid && op == cp0_pkg::OP_EXC;
    assign is_eret  = op_valid && op == cp0_pkg::OP_ERET;
    assign is_tlbp  = op_valid && op == cp0_pkg::OP_TLBP;
    assign is_tlbr  = op_valid && op == cp0_pkg::OP_TLBR;
    assign is_tlbwi = op_valid && op == cp0_pkg::OP_TLBWI;

    assign tlb_code  = exc_code == cp0_pkg::EXC_MOD || exc_code == cp0_pkg::EXC_TLBL ||
                       exc_code == cp0_pkg::EXC_TLBS;
    assign addr_code = exc_code == cp0_pkg::EXC_ADEL || exc_code == cp0_pkg::EXC_ADES;

    assign wd_status = wdata & cp0_pkg::STATUS_WMASK;
    assign wd_cause  = wdata & cp0_pkg::CAUSE_WMASK;
    assign wd_index  = wdata & cp0_pkg::INDEX_WMASK;

    always_ff @(posedge clk) begin
        if (reset) begin
            status_im  <= 8'h00;
            status_exl <= 1'b0;
            status_ie  <= 1'b0;
        end else if (is_exc) begin
            status_exl <= 1'b1;
        end else if (is_eret) begin
            status_exl <= 1'b0;
        end else if (mtc0 && addr == cp0_pkg::REG_STATUS) begin
            status_im  <= wd_status[15:8];
            status_exl <= wd_status[1];
            status_ie  <= wd_status[0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cause_bd       <= 1'b0;
            cause_exc_code <= 5'd0;
            cause_ip_sw    <= 2'b00;
        end else if (is_exc) begin
            cause_exc_code <= exc_code;
            if (!status_exl)  // Nested exception keeps the first BD
                cause_bd <= bd;
        end else if (mtc0 && addr == cp0_pkg::REG_CAUSE) begin
            cause_ip_sw <= wd_cause[9:8];
        end
    end

    // Count advances on every second clock
    always_ff @(posedge clk) begin
        if (reset) begin
            tick      <= 1'b0;
            count     <= 32'd0;
            compare   <= cp0_pkg::COMPARE_RESET;
            cause_ti  <= 1'b0;
            ext_int_q <= 6'd0;
        end else begin
            tick      <= ~tick;
            ext_int_q <= ext_int;
            if (mtc0 && addr == cp0_pkg::REG_COUNT)
                count <= wdata;
            else if (tick)
                count <= count + 32'd1;
            if (mtc0 && addr == cp0_pkg::REG_COMPARE) begin
                compare  <= wdata;
                cause_ti <= 1'b0;  // Writing Compare acknowledges the timer
            end else if (count == compare) begin
                cause_ti <= 1'b1;
            end
        end
    end

    assign cause_ip = {cause_ti | ext_int_q[5], ext_int_q[4:0], cause_ip_sw};
    assign int_req  = status_ie && !status_exl && |(status_im & cause_ip);

    always_ff @(posedge clk) begin
        if (is_exc && !status_exl)
            epc <= bd ? pc - 32'd4 : pc;  // Point back at the branch
        else if (mtc0 && addr == cp0_pkg::REG_EPC)
            epc <= wdata;
        if (is_exc && (addr_code || tlb_code))
            badvaddr_q <= badvaddr;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            entryhi   <= 32'd0;
            entrylo0  <= 32'd0;
            entrylo1  <= 32'd0;
            index_p   <= 1'b0;
            index_val <= '0;
        end else if (is_exc && tlb_code) begin
            entryhi[31:13] <= badvaddr[31:13];  // Faulting VPN2 for the refill handler
        end else if (is_tlbp) begin
            index_p <= !probe_hit;
            if (probe_hit)
                index_val <= probe_index;
        end else if (is_tlbr) begin
            entryhi  <= rd_entryhi;
            entrylo0 <= rd_entrylo0;
            entrylo1 <= rd_entrylo1;
        end else if (mtc0) begin
            case (addr)
                cp0_pkg::REG_ENTRYHI:  entryhi   <= wdata & cp0_pkg::ENTRYHI_WMASK;
                cp0_pkg::REG_ENTRYLO0: entrylo0  <= wdata & cp0_pkg::ENTRYLO_WMASK;
                cp0_pkg::REG_ENTRYLO1: entrylo1  <= wdata & cp0_pkg::ENTRYLO_WMASK;
                cp0_pkg::REG_INDEX:    index_val <= wd_index[cp0_pkg::TLB_IDX_W-1:0];
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            tlb_we <= 1'b0;
        else
            tlb_we <= is_tlbwi;  // Entry is written one cycle after the strobe
    end

    assign tlb_entryhi  = entryhi;
    assign tlb_entrylo0 = entrylo0;
    assign tlb_entrylo1 = entrylo1;
    assign tlb_index    = index_val;

    always_comb begin
        case (addr)
            cp0_pkg::REG_INDEX:
                read_data = {index_p, {(31 - cp0_pkg::TLB_IDX_W){1'b0}}, index_val};
            cp0_pkg::REG_ENTRYLO0: read_data = entrylo0;
            cp0_pkg::REG_ENTRYLO1: read_data = entrylo1;
            cp0_pkg::REG_BADVADDR: read_data = badvaddr_q;
            cp0_pkg::REG_COUNT:    read_data = count;
            cp0_pkg::REG_ENTRYHI:  read_data = entryhi;
            cp0_pkg::REG_COMPARE:  read_data = compare;
            cp0_pkg::REG_STATUS:   // BEV reads as one
                read_data = {9'd0, 1'b1, 6'd0, status_im, 6'd0, status_exl, status_ie};
            cp0_pkg::REG_CAUSE:
                read_data = {cause_bd, cause_ti, 14'd0, cause_ip, 1'b0, cause_exc_code, 2'b00};
            cp0_pkg::REG_EPC:      read_data = epc;
            default:               read_data = 32'd0;
        endcase
    end

    // Delayed TLB write must land before the next command can read or probe
    a_we_between_ops: assert property (@(posedge clk) disable iff (reset)
        tlb_we |-> !op_valid);

endmodule

// ==== rtl/cp0_tlb.sv ====
`timescale 1ns/1ns

module cp0_tlb (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [31:0]                   entryhi,
    input  logic [31:0]                   entrylo0,
    input  logic [31:0]                   entrylo1,
    input  logic [cp0_pkg::TLB_IDX_W-1:0] index,
    input  logic                          we,
    output logic                          probe_hit,
    output logic [cp0_pkg::TLB_IDX_W-1:0] probe_index,
    output logic [31:0]                   rd_entryhi,
    output logic [31:0]                   rd_entrylo0,
    output logic [31:0]                   rd_entrylo1
);
    logic [18:0] vpn2 [cp0_pkg::TLB_ENTRIES];
    logic [7:0]  asid [cp0_pkg::TLB_ENTRIES];
    logic [24:0] lo0  [cp0_pkg::TLB_ENTRIES];  // PFN, C, D, V of the even page
    logic [24:0] lo1  [cp0_pkg::TLB_ENTRIES];  // Same for the odd page
    logic [cp0_pkg::TLB_ENTRIES-1:0] valid;
    logic [cp0_pkg::TLB_ENTRIES-1:0] g;
    logic [cp0_pkg::TLB_ENTRIES-1:0] match;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < cp0_pkg::TLB_ENTRIES; i++) begin
                vpn2[i] <= 19'd0;
                asid[i] <= 8'd0;
                lo0[i]  <= 25'd0;
                lo1[i]  <= 25'd0;
            end
            valid <= '0;
            g     <= '0;
        end else if (we) begin
            valid[index] <= 1'b1;
            vpn2[index]  <= entryhi[31:13];
            asid[index]  <= entryhi[7:0];
            g[index]     <= entrylo0[0] & entrylo1[0];  // Global only if both halves agree
            lo0[index]   <= entrylo0[25:1];
            lo1[index]   <= entrylo1[25:1];
        end
    end

    // Fully associative search against the current EntryHi
    always_comb begin
        match       = '0;
        probe_index = '0;
        for (int i = 0; i < cp0_pkg::TLB_ENTRIES; i++) begin
            match[i] = valid[i] && vpn2[i] == entryhi[31:13] &&
                       (g[i] || asid[i] == entryhi[7:0]);
            if (match[i])
                probe_index = i[cp0_pkg::TLB_IDX_W-1:0];
        end
    end

    assign probe_hit = |match;

    assign rd_entryhi  = {vpn2[index], 5'd0, asid[index]};
    assign rd_entrylo0 = {6'd0, lo0[index], g[index]};  // Both G bits return stored G
    assign rd_entrylo1 = {6'd0, lo1[index], g[index]};

    a_single_hit: assert property (@(posedge clk) disable iff (reset)
        $onehot0(match));

endmodule

// ==== rtl/cp0_resp_port.sv ====
`timescale 1ns/1ns

module cp0_resp_port (
    input  logic             clk,
    input  logic             reset,
    input  logic             op_valid,
    input  cp0_pkg::cp0_op_e op,
    input  logic [31:0]      read_data,
    input  logic [31:0]      epc,
    output logic             op_done,
    output logic [31:0]      rsp_rdata,
    output logic             rsp_redirect,
    output logic [31:0]      rsp_target
);
    logic done_pend;

    always_ff @(posedge clk) begin
        if (reset) begin
            done_pend    <= 1'b0;
            op_done      <= 1'b0;
            rsp_redirect <= 1'b0;
        end else begin
            done_pend <= op_valid;
            op_done   <= done_pend;  // Result has been stable for a full cycle
            if (op_valid)
                rsp_redirect <= op == cp0_pkg::OP_EXC || op == cp0_pkg::OP_ERET;
        end
    end

    // EPC is sampled on the same edge that ERET updates state, so this is the old value
    always_ff @(posedge clk) begin
        if (op_valid) begin
            rsp_rdata  <= read_data;
            rsp_target <= (op == cp0_pkg::OP_EXC) ? cp0_pkg::EXC_VECTOR : epc;
        end
    end

endmodule

// ==== rtl/cp0_subsys.sv ====
`timescale 1ns/1ns

module cp0_subsys (
    input  logic             clk,
    input  logic             reset,
    input  logic             cmd_req,
    output logic             cmd_ack,
    input  cp0_pkg::cp0_op_e cmd_op,
    input  logic [7:0]       cmd_addr,
    input  logic [31:0]      cmd_wdata,
    input  logic [31:0]      cmd_pc,
    input  logic             cmd_bd,
    input  logic [4:0]       cmd_exc_code,
    input  logic [31:0]      cmd_badvaddr,
    input  logic [5:0]       ext_int,
    output logic [31:0]      rsp_rdata,
    output logic             rsp_redirect,
    output logic [31:0]      rsp_target,
    output logic             int_req
);
    logic             op_valid;
    cp0_pkg::cp0_op_e op;
    logic [7:0]       addr;
    logic [31:0]      wdata, pc, badvaddr;
    logic             bd;
    logic [4:0]       exc_code;
    logic             op_done;
    logic [31:0]      read_data, epc;
    logic [31:0]      tlb_entryhi, tlb_entrylo0, tlb_entrylo1;
    logic [cp0_pkg::TLB_IDX_W-1:0] tlb_index, probe_index;
    logic             tlb_we, probe_hit;
    logic [31:0]      rd_entryhi, rd_entrylo0, rd_entrylo1;

    cp0_cmd_port cmd_port_inst (
        .clk, .reset, .cmd_req, .cmd_ack, .cmd_op, .cmd_addr, .cmd_wdata, .cmd_pc,
        .cmd_bd, .cmd_exc_code, .cmd_badvaddr, .op_done, .op_valid, .op, .addr,
        .wdata, .pc, .bd, .exc_code, .badvaddr
    );

    cp0_regs regs_inst (
        .clk, .reset, .op_valid, .op, .addr, .wdata, .pc, .bd, .exc_code, .badvaddr,
        .ext_int, .read_data, .epc, .int_req, .tlb_entryhi, .tlb_entrylo0,
        .tlb_entrylo1, .tlb_index, .tlb_we, .probe_hit, .probe_index, .rd_entryhi,
        .rd_entrylo0, .rd_entrylo1
    );

    cp0_tlb tlb_inst (
        .clk, .reset, .entryhi(tlb_entryhi), .entrylo0(tlb_entrylo0),
        .entrylo1(tlb_entrylo1), .index(tlb_index), .we(tlb_we), .probe_hit,
        .probe_index, .rd_entryhi, .rd_entrylo0, .rd_entrylo1
    );

    cp0_resp_port resp_port_inst (
        .clk, .reset, .op_valid, .op, .read_data, .epc, .op_done, .rsp_rdata,
        .rsp_redirect, .rsp_target
    );

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk,
    output logic reset
);
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clk);
        #2 reset = 1'b0;  // Released just after the edge like every other input
    end

endmodule

// ==== verification/cp0_ref.svh ====
`ifndef CP0_REF_SVH
`define CP0_REF_SVH

// Shadow of the CP0 state, advanced in command order
logic [7:0]  sh_im;
logic        sh_exl, sh_ie, sh_bd, sh_ti, sh_p;
logic [1:0]  sh_ip_sw;
logic [4:0]  sh_code;
logic [5:0]  sh_ext;
logic [31:0] sh_compare, sh_epc, sh_badv, sh_hi, sh_lo0, sh_lo1;
logic [cp0_pkg::TLB_IDX_W-1:0]   sh_idx;
logic [cp0_pkg::TLB_ENTRIES-1:0] sh_valid, sh_g;
logic [18:0] sh_vpn2 [cp0_pkg::TLB_ENTRIES];
logic [7:0]  sh_asid [cp0_pkg::TLB_ENTRIES];
logic [24:0] sh_pg0  [cp0_pkg::TLB_ENTRIES];  // PFN, C, D, V of each page
logic [24:0] sh_pg1  [cp0_pkg::TLB_ENTRIES];

function automatic void reset_shadow();
    {sh_im, sh_exl, sh_ie, sh_bd, sh_ti, sh_p, sh_ip_sw, sh_code, sh_ext} = '0;
    sh_compare = cp0_pkg::COMPARE_RESET;
    sh_epc     = 'x;  // No reset value
    sh_badv    = 'x;
    {sh_hi, sh_lo0, sh_lo1, sh_idx, sh_valid, sh_g} = '0;
endfunction

function automatic logic ref_tlb_code(input logic [4:0] code);
    return code == cp0_pkg::EXC_MOD || code == cp0_pkg::EXC_TLBL || code == cp0_pkg::EXC_TLBS;
endfunction

function automatic logic ref_badv_code(input logic [4:0] code);
    return ref_tlb_code(code) || code == cp0_pkg::EXC_ADEL || code == cp0_pkg::EXC_ADES;
endfunction

// Returns {hit, index}
function automatic logic [cp0_pkg::TLB_IDX_W:0] ref_probe();
    for (int i = 0; i < cp0_pkg::TLB_ENTRIES; i++) begin
        if (sh_valid[i] && sh_vpn2[i] == sh_hi[31:13] &&
            (sh_g[i] || sh_asid[i] == sh_hi[7:0]))
            return {1'b1, i[cp0_pkg::TLB_IDX_W-1:0]};
    end
    return '0;
endfunction

// Expected MFC0 value; Count is never predicted
function automatic logic [31:0] ref_read(input logic [7:0] a);
    logic [7:0] ip;
    ip = {sh_ti | sh_ext[5], sh_ext[4:0], sh_ip_sw};
    case (a)
        cp0_pkg::REG_INDEX:    return {sh_p, 27'd0, sh_idx};
        cp0_pkg::REG_ENTRYLO0: return sh_lo0;
        cp0_pkg::REG_ENTRYLO1: return sh_lo1;
        cp0_pkg::REG_BADVADDR: return sh_badv;
        cp0_pkg::REG_ENTRYHI:  return sh_hi;
        cp0_pkg::REG_COMPARE:  return sh_compare;
        cp0_pkg::REG_STATUS:   return 32'h0040_0000 | {16'd0, sh_im, 6'd0, sh_exl, sh_ie};
        cp0_pkg::REG_CAUSE:    return {sh_bd, sh_ti, 14'd0, ip, 1'b0, sh_code, 2'b00};
        cp0_pkg::REG_EPC:      return sh_epc;
        default:               return 32'd0;
    endcase
endfunction

function automatic void ref_write(input logic [7:0] a, input logic [31:0] w);
    logic [31:0] ws;
    logic [31:0] wc;
    logic [31:0] wi;
    ws = w & cp0_pkg::STATUS_WMASK;
    wc = w & cp0_pkg::CAUSE_WMASK;
    wi = w & cp0_pkg::INDEX_WMASK;
    case (a)
        cp0_pkg::REG_STATUS:   {sh_im, sh_exl, sh_ie} = {ws[15:8], ws[1], ws[0]};
        cp0_pkg::REG_CAUSE:    sh_ip_sw = wc[9:8];
        cp0_pkg::REG_COMPARE:  {sh_compare, sh_ti} = {w, 1'b0};  // Timer acknowledged
        cp0_pkg::REG_EPC:      sh_epc = w;
        cp0_pkg::REG_ENTRYHI:  sh_hi = w & cp0_pkg::ENTRYHI_WMASK;
        cp0_pkg::REG_ENTRYLO0: sh_lo0 = w & cp0_pkg::ENTRYLO_WMASK;
        cp0_pkg::REG_ENTRYLO1: sh_lo1 = w & cp0_pkg::ENTRYLO_WMASK;
        cp0_pkg::REG_INDEX:    sh_idx = wi[cp0_pkg::TLB_IDX_W-1:0];
        default: ;
    endcase
endfunction

function automatic void ref_apply(input cp0_pkg::cp0_op_e op, input logic [7:0] a,
                                  input logic [31:0] w, input logic [31:0] pc, input logic bd,
                                  input logic [4:0] code, input logic [31:0] bv);
    logic [cp0_pkg::TLB_IDX_W:0] pr;
    pr = ref_probe();
    case (op)
        cp0_pkg::OP_MTC0: ref_write(a, w);
        cp0_pkg::OP_EXC: begin
            if (!sh_exl) begin  // First level only
                sh_bd  = bd;
                sh_epc = bd ? pc - 32'd4 : pc;
            end
            sh_exl  = 1'b1;
            sh_code = code;
            if (ref_badv_code(code))
                sh_badv = bv;
            if (ref_tlb_code(code))
                sh_hi[31:13] = bv[31:13];
        end
        cp0_pkg::OP_ERET: sh_exl = 1'b0;
        cp0_pkg::OP_TLBP: begin
            sh_p = !pr[cp0_pkg::TLB_IDX_W];
            if (pr[cp0_pkg::TLB_IDX_W])
                sh_idx = pr[cp0_pkg::TLB_IDX_W-1:0];
        end
        cp0_pkg::OP_TLBR: begin
            sh_hi  = {sh_vpn2[sh_idx], 5'd0, sh_asid[sh_idx]};
            sh_lo0 = {6'd0, sh_pg0[sh_idx], sh_g[sh_idx]};
            sh_lo1 = {6'd0, sh_pg1[sh_idx], sh_g[sh_idx]};
        end
        cp0_pkg::OP_TLBWI: begin
            sh_valid[sh_idx] = 1'b1;
            sh_vpn2[sh_idx]  = sh_hi[31:13];
            sh_asid[sh_idx]  = sh_hi[7:0];
            sh_g[sh_idx]     = sh_lo0[0] & sh_lo1[0];  // Global needs both G bits
            sh_pg0[sh_idx]   = sh_lo0[25:1];
            sh_pg1[sh_idx]   = sh_lo1[25:1];
        end
        default: ;
    endcase
endfunction

task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp)
        fail_run($sformatf("Error at %0t ns: %s is %h, expected %h",
                           $time, what, got, exp));
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp)
        fail_run($sformatf("Error at %0t ns: %s is %b, expected %b",
                           $time, what, got, exp));
endtask

task automatic check_index(input logic [cp0_pkg::TLB_IDX_W-1:0] got,
                           input logic [cp0_pkg::TLB_IDX_W-1:0] exp, input string what);
    if (got !== exp)
        fail_run($sformatf("Error at %0t ns: %s is %0d, expected %0d",
                           $time, what, got, exp));
endtask

`endif

// ==== verification/cp0_tb.sv ====
`timescale 1ns/1ns

module cp0_tb;
    localparam int CYCLE_LIMIT = 20000;  // About 650 commands at 5 cycles plus timer waits

    logic             clk, reset;
    logic             cmd_req, cmd_ack, cmd_bd;
    cp0_pkg::cp0_op_e cmd_op;
    logic [7:0]       cmd_addr;
    logic [31:0]      cmd_wdata, cmd_pc, cmd_badvaddr;
    logic [4:0]       cmd_exc_code;
    logic [5:0]       ext_int;
    logic [31:0]      rsp_rdata, rsp_target;
    logic             rsp_redirect, int_req;

    integer           seed = 32'hc1f18e6d;
    int               cycle_count = 0;
    int               error_count = 0;
    event             result_ready;
    cp0_pkg::cp0_op_e exp_op;
    logic [7:0]       exp_addr;
    logic [31:0]      exp_rdata, exp_target;
    logic             exp_redirect;

    tb_clock_gen clock_gen_inst (.clk, .reset);

    cp0_subsys cp0_subsys_inst (
        .clk, .reset, .cmd_req, .cmd_ack, .cmd_op, .cmd_addr, .cmd_wdata, .cmd_pc,
        .cmd_bd, .cmd_exc_code, .cmd_badvaddr, .ext_int, .rsp_rdata, .rsp_redirect,
        .rsp_target, .int_req
    );

    task automatic fail_run(input string msg);
        error_count++;
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    `include "cp0_ref.svh"

    // Compares each finished command against the prediction made when it was issued
    always @(result_ready) begin
        check_flag(rsp_redirect, exp_redirect, "rsp_redirect");
        if (exp_redirect)
            check_word(rsp_target, exp_target, "rsp_target");
        if (exp_op == cp0_pkg::OP_MFC0) begin
            if (exp_addr == cp0_pkg::REG_INDEX) begin
                check_flag(rsp_rdata[31], exp_rdata[31], "Index.P");
                check_index(rsp_rdata[cp0_pkg::TLB_IDX_W-1:0],
                            exp_rdata[cp0_pkg::TLB_IDX_W-1:0], "Index");
            end
            check_word(rsp_rdata, exp_rdata, $sformatf("MFC0 of register %0d", exp_addr >> 3));
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT)
            fail_run($sformatf("Timeout: run did not finish in %0d cycles", CYCLE_LIMIT));
    end

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic do_cmd(input cp0_pkg::cp0_op_e op, input logic [7:0] a, input logic [31:0] w,
                          input logic [31:0] pc, input logic bd, input logic [4:0] code,
                          input logic [31:0] bv);
        exp_op       = op;
        exp_addr     = a;
        exp_rdata    = ref_read(a);
        exp_redirect = op == cp0_pkg::OP_EXC || op == cp0_pkg::OP_ERET;
        exp_target   = (op == cp0_pkg::OP_EXC) ? cp0_pkg::EXC_VECTOR : sh_epc;  // Old EPC
        ref_apply(op, a, w, pc, bd, code, bv);
        cmd_op       = op;
        cmd_addr     = a;
        cmd_wdata    = w;
        cmd_pc       = pc;
        cmd_bd       = bd;
        cmd_exc_code = code;
        cmd_badvaddr = bv;
        cmd_req      = 1'b1;
        do step(); while (!cmd_ack);
        -> result_ready;
        cmd_req = 1'b0;
        do step(); while (cmd_ack);  // Four-phase close
    endtask

    task automatic mtc0(input logic [7:0] a, input logic [31:0] w);
        do_cmd(cp0_pkg::OP_MTC0, a, w, 32'd0, 1'b0, 5'd0, 32'd0);
    endtask

    task automatic mfc0(input logic [7:0] a);
        do_cmd(cp0_pkg::OP_MFC0, a, 32'd0, 32'd0, 1'b0, 5'd0, 32'd0);
    endtask

    task automatic run_op(input cp0_pkg::cp0_op_e op);
        do_cmd(op, 8'd0, 32'd0, 32'd0, 1'b0, 5'd0, 32'd0);
    endtask

    task automatic drive_ext(input logic [5:0] v);
        ext_int = v;
        sh_ext  = v;
    endtask

    task automatic wait_int(input logic level, input int limit, input string what);
        int n;
        n = 0;
        while (int_req !== level && n < limit) begin
            step();
            n++;
        end
        if (int_req !== level)
            fail_run(what);
    endtask

    function automatic logic [4:0] pick_code(input logic [2:0] sel);
        case (sel)
            3'd0:    return cp0_pkg::EXC_INT;
            3'd1:    return cp0_pkg::EXC_MOD;
            3'd2:    return cp0_pkg::EXC_TLBL;
            3'd3:    return cp0_pkg::EXC_TLBS;
            3'd4:    return cp0_pkg::EXC_ADEL;
            3'd5:    return cp0_pkg::EXC_ADES;
            default: return cp0_pkg::EXC_SYS;
        endcase
    endfunction

    task automatic test_masks();
        repeat (8) begin
            mtc0(cp0_pkg::REG_STATUS, $random(seed));
            mfc0(cp0_pkg::REG_STATUS);
            mtc0(cp0_pkg::REG_CAUSE, $random(seed));
            mfc0(cp0_pkg::REG_CAUSE);
            mtc0(cp0_pkg::REG_INDEX, $random(seed));
            mfc0(cp0_pkg::REG_INDEX);
            mtc0(cp0_pkg::REG_ENTRYHI, $random(seed));
            mfc0(cp0_pkg::REG_ENTRYHI);
            mtc0(cp0_pkg::REG_ENTRYLO0, $random(seed));
            mfc0(cp0_pkg::REG_ENTRYLO0);
            mtc0(cp0_pkg::REG_ENTRYLO1, $random(seed));
            mfc0(cp0_pkg::REG_ENTRYLO1);
            mtc0(cp0_pkg::REG_EPC, $random(seed));
            mfc0(cp0_pkg::REG_EPC);
            mtc0(cp0_pkg::REG_COMPARE, $random(seed) | 32'h8000_0000);  // Far from Count
            mfc0(cp0_pkg::REG_COMPARE);
        end
    endtask

    task automatic test_exceptions();
        logic [31:0] r, pc, bv;
        logic [4:0]  code;
        repeat (12) begin
            r    = $random(seed);
            pc   = $random(seed) & 32'hFFFF_FFFC;
            bv   = $random(seed);
            code = pick_code(r[3:1]);
            mtc0(cp0_pkg::REG_STATUS, 32'h0);  // EXL clear so EPC gets written
            do_cmd(cp0_pkg::OP_EXC, 8'd0, 32'd0, pc, r[0], code, bv);
            mfc0(cp0_pkg::REG_EPC);
            mfc0(cp0_pkg::REG_CAUSE);
            mfc0(cp0_pkg::REG_STATUS);
            if (ref_badv_code(code))
                mfc0(cp0_pkg::REG_BADVADDR);
            if (ref_tlb_code(code))
                mfc0(cp0_pkg::REG_ENTRYHI);
            do_cmd(cp0_pkg::OP_EXC, 8'd0, 32'd0, pc + 32'h100, !r[0], cp0_pkg::EXC_SYS, 32'd0);
            mfc0(cp0_pkg::REG_EPC);
            mfc0(cp0_pkg::REG_CAUSE);
            run_op(cp0_pkg::OP_ERET);
            mfc0(cp0_pkg::REG_STATUS);
        end
    endtask

    task automatic test_tlb();
        logic [31:0] r, hi;
        logic [cp0_pkg::TLB_IDX_W-1:0] idx;
        repeat (24) begin
            r   = $random(seed);
            idx = r[cp0_pkg::TLB_IDX_W-1:0];
            r   = $random(seed);
            hi  = {r[31:17], idx, r[12:0]};  // VPN2 low bits equal the index, so no overlap
            mtc0(cp0_pkg::REG_INDEX, {28'd0, idx});
            mtc0(cp0_pkg::REG_ENTRYHI, hi);
            mtc0(cp0_pkg::REG_ENTRYLO0, $random(seed));
            mtc0(cp0_pkg::REG_ENTRYLO1, $random(seed));
            run_op(cp0_pkg::OP_TLBWI);
            mtc0(cp0_pkg::REG_ENTRYHI, hi ^ 32'h8000_0000);  // Absent VPN2
            run_op(cp0_pkg::OP_TLBP);
            mfc0(cp0_pkg::REG_INDEX);
            run_op(cp0_pkg::OP_TLBR);
            mfc0(cp0_pkg::REG_ENTRYHI);
            mfc0(cp0_pkg::REG_ENTRYLO0);
            mfc0(cp0_pkg::REG_ENTRYLO1);
            mtc0(cp0_pkg::REG_INDEX, {28'd0, ~idx});  // Probe hit has to restore the index
            run_op(cp0_pkg::OP_TLBP);
            mfc0(cp0_pkg::REG_INDEX);
        end
    endtask

    task automatic test_interrupts();
        logic [31:0] cmp, r;
        int          k;
        cmp = $random(seed) | 32'h8000_0000;
        mtc0(cp0_pkg::REG_STATUS, 32'h0);
        mtc0(cp0_pkg::REG_CAUSE, 32'h0);
        mtc0(cp0_pkg::REG_COMPARE, cmp);
        mtc0(cp0_pkg::REG_COUNT, cmp - 32'd4);
        mtc0(cp0_pkg::REG_STATUS, 32'h0000_8001);  // IM7 and IE
        wait_int(1'b1, 20, "int_req did not rise within 20 cycles of the timer match");
        sh_ti = 1'b1;
        mfc0(cp0_pkg::REG_CAUSE);
        mtc0(cp0_pkg::REG_COMPARE, cmp + 32'h4000_0000);
        check_flag(int_req, 1'b0, "int_req after Compare write");
        mfc0(cp0_pkg::REG_CAUSE);
        r = $random(seed);
        k = r[7:0] % 5;
        mtc0(cp0_pkg::REG_STATUS, 32'h0000_0001);  // Line masked
        drive_ext(6'b1 << k);
        repeat (3) step();
        check_flag(int_req, 1'b0, "int_req with the line masked");
        mfc0(cp0_pkg::REG_CAUSE);
        mtc0(cp0_pkg::REG_STATUS, 32'h0000_0001 | (32'h0000_0400 << k));
        wait_int(1'b1, 4, "int_req did not rise for an enabled external line");
        drive_ext(6'd0);
        wait_int(1'b0, 4, "int_req did not fall after the external line dropped");
    endtask

    initial begin
        cmd_req      = 1'b0;
        cmd_op       = cp0_pkg::OP_MFC0;
        cmd_addr     = 8'd0;
        cmd_wdata    = 32'd0;
        cmd_pc       = 32'd0;
        cmd_bd       = 1'b0;
        cmd_exc_code = 5'd0;
        cmd_badvaddr = 32'd0;
        ext_int      = 6'd0;
        reset_shadow();
        wait (reset === 1'b0);
        step();
        mfc0(cp0_pkg::REG_STATUS);  // Reset values
        mfc0(cp0_pkg::REG_CAUSE);
        mfc0(cp0_pkg::REG_COMPARE);
        test_masks();
        test_exceptions();
        test_tlb();
        test_interrupts();
        if (error_count == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            fail_run("One or more checks failed during the run");
        end
    end

endmodule

// ==== list.f ====
+incdir+verification
rtl/cp0_pkg.sv
rtl/cp0_cmd_port.sv
rtl/cp0_regs.sv
rtl/cp0_tlb.sv
rtl/cp0_resp_port.sv
rtl/cp0_subsys.sv
verification/tb_clock_gen.sv
verification/cp0_tb.sv

// ==== Bender.yml ====
package:
  name: cp0_subsys

sources:
  - rtl/cp0_pkg.sv
  - rtl/cp0_cmd_port.sv
  - rtl/cp0_regs.sv
  - rtl/cp0_tlb.sv
  - rtl/cp0_resp_port.sv
  - rtl/cp0_subsys.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/tb_clock_gen.sv
      - verification/cp0_tb.sv
